// File: hdc_pkg.sv
`default_nettype none

package hdc_pkg;

    // opcode field width
    localparam int op_w = 4;

    // argument width
    // item address for gen/load/wb, rotate amount for perm
    localparam int arg_w = 12;

    // instruction opcodes
    typedef enum logic [op_w-1:0] {
        op_nop   = 4'd0,
        op_gen   = 4'd1,
        op_load  = 4'd2,
        op_xor   = 4'd3,
        op_perm  = 4'd4,
        op_move  = 4'd5,
        op_store = 4'd6,
        op_wb    = 4'd7
    } op_t;

    // 16 bit instruction word from the host
    typedef struct packed {
        op_t              op;
        logic [arg_w-1:0] arg;
    } instr_t;

    // decoded command, sequencer to datapath
    // fire is a one cycle execute strobe
    typedef struct packed {
        logic             fire;
        op_t              op;
        logic [arg_w-1:0] arg;
    } ctl_t;

endpackage

`default_nettype wire

// File: item_memory.sv
`timescale 1ns/1ns
`default_nettype none

module item_memory #(
    parameter int hv_width  = 64,
    parameter int mem_depth = 512
) (
    input  wire logic                         clk,
    input  wire logic                         wr_en,
    input  wire logic [$clog2(mem_depth)-1:0] wr_addr,
    input  wire logic [hv_width-1:0]          wr_data,
    input  wire logic [$clog2(mem_depth)-1:0] rd_addr,
    output logic      [hv_width-1:0]          rd_data
);

    // address width derived from depth
    localparam int addr_w = $clog2(mem_depth);

    // item store, one hypervector per entry
    // no reset, contents undefined until generated
    logic [hv_width-1:0] mem [mem_depth];

    // single write port
    always_ff @(posedge clk) begin
        if (wr_en) begin
            mem[wr_addr] <= wr_data;
        end
    end

    // read port always streams
    // one cycle of latency, old data on a same-address write
    always_ff @(posedge clk) begin
        rd_data <= mem[rd_addr[addr_w-1:0]];
    end

endmodule

`default_nettype wire

// File: instr_sequencer.sv
`timescale 1ns/1ns
`default_nettype none

module instr_sequencer #(
    parameter int mem_depth = 512
) (
    input  wire logic                         clk,
    input  wire logic                         reset,
    input  wire logic                         req,
    input  wire hdc_pkg::instr_t              instr,
    output logic                              ack,
    output hdc_pkg::ctl_t                     ctl,
    output logic      [$clog2(mem_depth)-1:0] rd_addr
);

    localparam int addr_w = $clog2(mem_depth);

    // handshake and execute sequence
    // idle   waiting for req
    // read   address out, memory read in flight
    // exec   read data ready, fire high for this cycle
    // hold   ack high until req drops
    typedef enum logic [1:0] {
        st_idle,
        st_read,
        st_exec,
        st_hold
    } state_t;

    state_t          state;
    state_t          state_nxt;
    hdc_pkg::instr_t instr_q;

    // next state
    always_comb begin
        state_nxt = state;
        case (state)
            st_idle: begin
                // ack is already low whenever we sit in idle
                if (req) begin
                    state_nxt = st_read;
                end
            end
            st_read: begin
                state_nxt = st_exec;
            end
            st_exec: begin
                state_nxt = st_hold;
            end
            st_hold: begin
                // back-pressure, nothing runs again while req stays high
                if (!req) begin
                    state_nxt = st_idle;
                end
            end
            default: begin
                state_nxt = st_idle;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            state <= st_idle;
        end else begin
            state <= state_nxt;
        end
    end

    // instruction latch on acceptance
    // host keeps instr stable, but the copy frees it after E0
    always_ff @(posedge clk) begin
        if (state == st_idle && req) begin
            instr_q <= instr;
        end
    end

    // read address straight from the latch, valid from E0
    // only the low bits of arg address the memory
    assign rd_addr = instr_q.arg[addr_w-1:0];

    // command to the datapath
    always_comb begin
        ctl.fire = (state == st_exec);
        ctl.op   = instr_q.op;
        ctl.arg  = instr_q.arg;
    end

    // ack rises on the edge the datapath updates
    // falls on the edge after req is seen low
    assign ack = (state == st_hold);

endmodule

`default_nettype wire

// File: hv_datapath.sv
`timescale 1ns/1ns
`default_nettype none

module hv_datapath #(
    parameter int hv_width  = 64,
    parameter int mem_depth = 512
) (
    input  wire logic                         clk,
    input  wire logic                         reset,
    input  wire hdc_pkg::ctl_t                ctl,
    input  wire logic [hv_width-1:0]          rd_data,
    input  wire logic [hv_width-1:0]          rand_vec,
    output logic                              wr_en,
    output logic      [$clog2(mem_depth)-1:0] wr_addr,
    output logic      [hv_width-1:0]          wr_data,
    output logic      [hv_width-1:0]          result,
    output logic                              result_valid
);

    localparam int addr_w = $clog2(mem_depth);

    // reg_a holds the bound operand
    // reg_b is the working register
    logic [hv_width-1:0] reg_a;
    logic [hv_width-1:0] reg_b;

    // permute path
    int unsigned         rot_amt;
    logic [hv_width-1:0] reg_b_rot;

    // rotate left by arg mod hv_width
    // bit i of reg_b lands on bit (i+k) mod hv_width
    always_comb begin
        rot_amt   = ctl.arg % hv_width;
        // k of zero shifts right by the full width, which gives zero
        reg_b_rot = (reg_b << rot_amt) | (reg_b >> (hv_width - rot_amt));
    end

    // register updates on fire
    always_ff @(posedge clk) begin
        if (reset) begin
            reg_a <= '0;
            reg_b <= '0;
        end else if (ctl.fire) begin
            case (ctl.op)
                hdc_pkg::op_load: begin
                    reg_b <= rd_data;
                end
                hdc_pkg::op_xor: begin
                    // bind
                    reg_b <= reg_a ^ reg_b;
                end
                hdc_pkg::op_perm: begin
                    reg_b <= reg_b_rot;
                end
                hdc_pkg::op_move: begin
                    reg_a <= reg_b;
                end
                default: begin
                    // nop, store, gen and wb leave both registers alone
                end
            endcase
        end
    end

    // store output
    // result holds until the next store, valid pulses one cycle
    always_ff @(posedge clk) begin
        if (reset) begin
            result       <= '0;
            result_valid <= 1'b0;
        end else begin
            result_valid <= 1'b0;
            if (ctl.fire && ctl.op == hdc_pkg::op_store) begin
                result       <= reg_b;
                result_valid <= 1'b1;
            end
        end
    end

    // memory write port, combinational from ctl
    // lands on the same edge as ack
    always_comb begin
        wr_en   = ctl.fire && (ctl.op == hdc_pkg::op_gen || ctl.op == hdc_pkg::op_wb);
        wr_addr = ctl.arg[addr_w-1:0];
        // gen stores the host random vector, wb the working register
        if (ctl.op == hdc_pkg::op_gen) begin
            wr_data = rand_vec;
        end else begin
            wr_data = reg_b;
        end
    end

endmodule

`default_nettype wire

// File: hdc_core.sv
`timescale 1ns/1ns
`default_nettype none

module hdc_core #(
    parameter int hv_width  = 64,
    parameter int mem_depth = 512
) (
    input  wire logic                clk,
    input  wire logic                reset,
    input  wire logic                req,
    input  wire hdc_pkg::instr_t     instr,
    output logic                     ack,
    input  wire logic [hv_width-1:0] rand_vec,
    output logic      [hv_width-1:0] result,
    output logic                     result_valid
);

    localparam int addr_w = $clog2(mem_depth);

    // sequencer to datapath
    hdc_pkg::ctl_t       ctl;

    // memory ports
    logic [addr_w-1:0]   rd_addr;
    logic [hv_width-1:0] rd_data;
    logic                wr_en;
    logic [addr_w-1:0]   wr_addr;
    logic [hv_width-1:0] wr_data;

    // handshake, decode and read address
    instr_sequencer #(
        .mem_depth (mem_depth)
    ) u_instr_sequencer (
        .clk     (clk),
        .reset   (reset),
        .req     (req),
        .instr   (instr),
        .ack     (ack),
        .ctl     (ctl),
        .rd_addr (rd_addr)
    );

    // working registers, bind and permute
    hv_datapath #(
        .hv_width  (hv_width),
        .mem_depth (mem_depth)
    ) u_hv_datapath (
        .clk          (clk),
        .reset        (reset),
        .ctl          (ctl),
        .rd_data      (rd_data),
        .rand_vec     (rand_vec),
        .wr_en        (wr_en),
        .wr_addr      (wr_addr),
        .wr_data      (wr_data),
        .result       (result),
        .result_valid (result_valid)
    );

    // hypervector store
    item_memory #(
        .hv_width  (hv_width),
        .mem_depth (mem_depth)
    ) u_item_memory (
        .clk     (clk),
        .wr_en   (wr_en),
        .wr_addr (wr_addr),
        .wr_data (wr_data),
        .rd_addr (rd_addr),
        .rd_data (rd_data)
    );

endmodule

`default_nettype wire

// File: tb_hdc_core.sv
`timescale 1ns/1ns
`default_nettype none

module tb_hdc_core;

    localparam int hv_width   = 64;
    localparam int mem_depth  = 512;
    // edges allowed for any single wait
    localparam int wait_limit = 20;

    logic                clk;
    logic                reset;
    logic                req;
    hdc_pkg::instr_t     instr;
    logic                ack;
    logic [hv_width-1:0] rand_vec;
    logic [hv_width-1:0] result;
    logic                result_valid;

    // reference model, working registers and memory shadow
    logic [hv_width-1:0] m_a;
    logic [hv_width-1:0] m_b;
    logic [hv_width-1:0] shadow [mem_depth];

    integer seed;
    int     errors;
    int     checks;
    int     tests;
    int     errors_at_start;

    hdc_core #(
        .hv_width  (hv_width),
        .mem_depth (mem_depth)
    ) u_hdc_core (
        .clk          (clk),
        .reset        (reset),
        .req          (req),
        .instr        (instr),
        .ack          (ack),
        .rand_vec     (rand_vec),
        .result       (result),
        .result_valid (result_valid)
    );

    // 4 ns clock
    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    task automatic report_error(input string msg);
        errors++;
        $display("[ERROR] %0t ns: %s", $time, msg);
    endtask

    task automatic abort_run(input string why);
        $display("run stopped at %0t ns: %s", $time, why);
        $display(">>> FAIL");
        $finish;
    endtask

    task automatic finish_test(input string name);
        tests++;
        $display("test %-12s %0d errors", name, errors - errors_at_start);
        errors_at_start = errors;
    endtask

    task automatic check_result(input logic [hv_width-1:0] got, input logic [hv_width-1:0] exp,
                                input string what);
        checks++;
        assert (got == exp)
        else report_error($sformatf("%s: got %h expected %h", what, got, exp));
    endtask

    // 32 bits of $random per word, low word first
    function automatic logic [hv_width-1:0] random_hv();
        logic [hv_width-1:0] v;
        logic [31:0]         w;
        w = '0;
        for (int i = 0; i < hv_width; i++) begin
            if (i % 32 == 0) begin
                w = $random(seed);
            end
            v[i] = w[i % 32];
        end
        return v;
    endfunction

    // bit i moves to bit (i+k) mod width
    function automatic logic [hv_width-1:0] rotate_left(input logic [hv_width-1:0] v,
                                                        input int k);
        logic [hv_width-1:0] r;
        r = '0;
        for (int i = 0; i < hv_width; i++) begin
            r[(i + k) % hv_width] = v[i];
        end
        return r;
    endfunction

    // full four-phase transfer, entered and left 1 ns after an edge
    task automatic issue_instr(input hdc_pkg::op_t op, input int arg, input int hold_extra);
        int edges;
        int pulses;
        int addr;
        addr      = arg % mem_depth;
        instr.op  = op;
        instr.arg = arg[hdc_pkg::arg_w-1:0];
        if (op == hdc_pkg::op_gen) begin
            rand_vec = random_hv();
        end
        req    = 1'b1;
        edges  = 0;
        pulses = 0;
        // accept, read, execute
        do begin
            @(posedge clk);
            #1;
            edges++;
            if (result_valid) pulses++;
            if (edges > wait_limit) abort_run("ack never rose after req");
        end while (!ack);
        checks++;
        assert (edges == 3)
        else report_error($sformatf("%s: ack rose on edge %0d", op.name(), edges));
        if (op == hdc_pkg::op_store) begin
            check_result(result, m_b, "store result");
        end
        // back-pressure, req held past ack
        repeat (hold_extra) begin
            @(posedge clk);
            #1;
            if (result_valid) pulses++;
            checks++;
            assert (ack) else report_error("ack dropped while req still high");
        end
        req   = 1'b0;
        edges = 0;
        do begin
            @(posedge clk);
            #1;
            edges++;
            if (result_valid) pulses++;
            if (edges > wait_limit) abort_run("ack never fell after req dropped");
        end while (ack);
        checks++;
        assert (edges == 1)
        else report_error($sformatf("%s: ack fell %0d edges after req", op.name(), edges));
        checks++;
        assert (pulses == ((op == hdc_pkg::op_store) ? 1 : 0))
        else report_error($sformatf("%s: %0d result_valid pulses", op.name(), pulses));
        // model update
        case (op)
            hdc_pkg::op_gen:  shadow[addr] = rand_vec;
            hdc_pkg::op_load: m_b = shadow[addr];
            hdc_pkg::op_xor:  m_b = m_a ^ m_b;
            hdc_pkg::op_perm: m_b = rotate_left(m_b, arg % hv_width);
            hdc_pkg::op_move: m_a = m_b;
            hdc_pkg::op_wb:   shadow[addr] = m_b;
            default: ;
        endcase
    endtask

    // handshake properties
    assert property (@(posedge clk) disable iff (reset)
        $rose(ack) |-> $past(req, 1) && $past(req, 2) && $past(req, 3) && !$past(req, 4))
    else report_error("ack rise not on the third edge after req");

    assert property (@(posedge clk) disable iff (reset) ack && req |=> ack)
    else report_error("ack fell while req held high");

    assert property (@(posedge clk) disable iff (reset) ack && !req |=> !ack)
    else report_error("ack still high one edge after req fell");

    assert property (@(posedge clk) disable iff (reset) result_valid |=> !result_valid)
    else report_error("result_valid longer than one cycle");

    assert property (@(posedge clk) disable iff (reset) $rose(result_valid) |-> $rose(ack))
    else report_error("result_valid not aligned with ack");

    initial begin
        int                  item_addr [5] = '{3, 100, 511, 0, 2567};
        int                  amounts [6]   = '{0, 1, 5, 33, hv_width - 1, hv_width + 3};
        logic [hv_width-1:0] saved [5];
        logic [hv_width-1:0] a;
        logic [hv_width-1:0] b;
        seed            = 32'h7f00_fc09;
        errors          = 0;
        checks          = 0;
        tests           = 0;
        errors_at_start = 0;
        reset           = 1'b1;
        req             = 1'b0;
        instr           = '0;
        rand_vec        = '0;
        m_a             = '0;
        m_b             = '0;
        repeat (2) @(posedge clk);
        #1;
        reset = 1'b0;

        check_result(result, '0, "result after reset");
        checks++;
        assert (!ack && !result_valid) else report_error("ack or result_valid high after reset");
        finish_test("reset");

        // 2567 aliases to address 7
        foreach (item_addr[i]) begin
            issue_instr(hdc_pkg::op_gen, item_addr[i], 0);
            saved[i] = rand_vec;
            issue_instr(hdc_pkg::op_load, item_addr[i], 0);
            issue_instr(hdc_pkg::op_store, 0, 0);
            check_result(result, saved[i], "fresh item");
        end
        // earlier items survive later writes
        foreach (item_addr[i]) begin
            issue_instr(hdc_pkg::op_load, item_addr[i], 0);
            issue_instr(hdc_pkg::op_store, 0, 0);
            check_result(result, saved[i], "older item");
        end
        finish_test("gen_load");

        issue_instr(hdc_pkg::op_gen, 10, 0);
        a = rand_vec;
        issue_instr(hdc_pkg::op_gen, 11, 0);
        b = rand_vec;
        issue_instr(hdc_pkg::op_load, 10, 0);
        issue_instr(hdc_pkg::op_move, 0, 0);
        issue_instr(hdc_pkg::op_load, 11, 0);
        issue_instr(hdc_pkg::op_xor, 0, 0);
        issue_instr(hdc_pkg::op_store, 0, 0);
        check_result(result, a ^ b, "bind");
        finish_test("bind");

        foreach (amounts[i]) begin
            issue_instr(hdc_pkg::op_load, 10, 0);
            issue_instr(hdc_pkg::op_perm, amounts[i], 0);
            issue_instr(hdc_pkg::op_store, 0, 0);
            check_result(result, rotate_left(a, amounts[i] % hv_width), "permute");
        end
        finish_test("permute");

        // bound vector written back, reg_b clobbered, then reloaded
        issue_instr(hdc_pkg::op_load, 10, 0);
        issue_instr(hdc_pkg::op_move, 0, 0);
        issue_instr(hdc_pkg::op_load, 11, 0);
        issue_instr(hdc_pkg::op_xor, 0, 0);
        issue_instr(hdc_pkg::op_wb, 200, 0);
        issue_instr(hdc_pkg::op_load, 3, 0);
        issue_instr(hdc_pkg::op_load, 200, 0);
        issue_instr(hdc_pkg::op_store, 0, 0);
        check_result(result, a ^ b, "write-back");
        finish_test("writeback");

        // held req on several opcodes, nop keeps both registers
        issue_instr(hdc_pkg::op_load, 3, 2);
        issue_instr(hdc_pkg::op_move, 0, 1);
        issue_instr(hdc_pkg::op_load, 100, 4);
        issue_instr(hdc_pkg::op_nop, 0, 0);
        issue_instr(hdc_pkg::op_store, 0, 3);
        check_result(result, saved[1], "store after nop");
        issue_instr(hdc_pkg::op_nop, 0, 2);
        issue_instr(hdc_pkg::op_xor, 0, 0);
        issue_instr(hdc_pkg::op_store, 0, 5);
        check_result(result, saved[0] ^ saved[1], "reg_a after nop");
        finish_test("handshake");

        $display("tests %0d, checks %0d, errors %0d", tests, checks, errors);
        if (errors == 0) begin
            $display(">>> PASS");
        end else begin
            $display(">>> FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: hdc_core.f
hdc_pkg.sv
item_memory.sv
instr_sequencer.sv
hv_datapath.sv
hdc_core.sv
tb_hdc_core.sv

// File: Makefile
# Verilator build and run of the hdc_core testbench

SIM  := obj_dir/Vtb_hdc_core
SRCS := $(shell cat hdc_core.f)

.PHONY: run clean

# rebuilt only when a source or the file list changes
$(SIM): hdc_core.f $(SRCS)
	verilator --binary --timing --assert --timescale 1ns/1ns \
		--top-module tb_hdc_core -f hdc_core.f

# pass or fail decided by the pass line in the log
run: $(SIM)
	./$(SIM) | tee sim.log
	grep -q '^>>> PASS$$' sim.log

clean:
	rm -rf obj_dir sim.log
